// ==== hdl/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

////////////////////////////////////////
// architectural widths
////////////////////////////////////////

`define MIPS_XLEN        32    // data and address word
`define MIPS_REG_ADDR_W  5     // register index
`define MIPS_NUM_REGS    32

// jal writes its return address here
`define MIPS_LINK_REG    31

`endif

// ==== hdl/mips_isa_pkg.sv ====
`default_nettype none

`include "mips_defines.svh"

package mips_isa_pkg;

	////////////////////////////////////////
	// primary opcode, bits 31:26
	////////////////////////////////////////
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,    // decoded further by funct
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	// function code of the special group, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// r-type view, i- and j-type fields overlay rd/shamt/funct
	typedef struct packed {
		opcode_e                     opcode;
		logic [`MIPS_REG_ADDR_W-1:0] rs;
		logic [`MIPS_REG_ADDR_W-1:0] rt;
		logic [`MIPS_REG_ADDR_W-1:0] rd;
		logic [4:0]                  shamt;
		funct_e                      funct;
	} inst_fields_t;

endpackage

`default_nettype wire

// ==== hdl/mips_pipe_pkg.sv ====
`default_nettype none

`include "mips_defines.svh"

package mips_pipe_pkg;

	////////////////////////////////////////
	// execute-stage operation
	////////////////////////////////////////
	typedef enum logic [7:0] {
		ALU_NOP   = 8'b00000000,
		ALU_AND   = 8'b00100100,
		ALU_OR    = 8'b00100101,
		ALU_XOR   = 8'b00100110,
		ALU_NOR   = 8'b00100111,
		ALU_SLL   = 8'b01111100,
		ALU_SRL   = 8'b00000010,
		ALU_SRA   = 8'b00000011,
		ALU_SLT   = 8'b00101010,
		ALU_SLTU  = 8'b00101011,
		ALU_ADD   = 8'b00100000,
		ALU_ADDU  = 8'b00100001,
		ALU_SUB   = 8'b00100010,
		ALU_SUBU  = 8'b00100011,
		ALU_ADDI  = 8'b01010101,
		ALU_ADDIU = 8'b01010110,
		ALU_J     = 8'b01001111,
		ALU_JAL   = 8'b01010000,
		ALU_JR    = 8'b00001000,
		ALU_JALR  = 8'b00001001,
		ALU_BEQ   = 8'b01010001,
		ALU_BNE   = 8'b01010010,
		ALU_BLEZ  = 8'b01010011,
		ALU_BGTZ  = 8'b01010100,
		ALU_LW    = 8'b11100011,
		ALU_SW    = 8'b11101011
	} alu_op_e;

	// result class, picks the execute result mux
	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_JUMP,    // j, jal
		BR_JREG,    // jr, jalr
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ
	} br_kind_e;

	////////////////////////////////////////
	// buses between stages
	////////////////////////////////////////

	// result of a later stage, looped back for forwarding
	typedef struct packed {
		logic                        we;
		logic [`MIPS_REG_ADDR_W-1:0] waddr;
		logic [`MIPS_XLEN-1:0]       wdata;
		alu_op_e                     alu_op;
	} fwd_bus_t;

	typedef struct packed {
		alu_op_e                     alu_op;
		alu_sel_e                    alu_sel;
		logic                        rd1_en;
		logic                        rd2_en;
		logic [`MIPS_REG_ADDR_W-1:0] rd1_addr;
		logic [`MIPS_REG_ADDR_W-1:0] rd2_addr;
		logic [`MIPS_REG_ADDR_W-1:0] waddr;
		logic                        we;
		logic [`MIPS_XLEN-1:0]       imm;    // operand for a port that does not read
		br_kind_e                    br_kind;
	} decode_ctrl_t;

	typedef struct packed {
		logic                        valid;
		alu_op_e                     alu_op;
		alu_sel_e                    alu_sel;
		logic [`MIPS_XLEN-1:0]       op1;
		logic [`MIPS_XLEN-1:0]       op2;
		logic [`MIPS_REG_ADDR_W-1:0] waddr;
		logic                        we;
		logic [`MIPS_XLEN-1:0]       link_addr;
		logic                        in_delay_slot;
		logic [`MIPS_XLEN-1:0]       inst;
	} id_ex_t;

	typedef struct packed {
		logic                        en;
		logic [`MIPS_REG_ADDR_W-1:0] addr;
		logic [`MIPS_XLEN-1:0]       data;
	} gpr_wr_t;

endpackage

`default_nettype wire

// ==== hdl/gpr_file.sv ====
`default_nettype none

`include "mips_defines.svh"

module gpr_file (
	input  wire                              clk_i,
	input  wire                              arst_n_i,
	input  wire mips_pipe_pkg::gpr_wr_t      wr_i,
	input  wire [`MIPS_REG_ADDR_W-1:0]       rd1_addr_i,
	input  wire [`MIPS_REG_ADDR_W-1:0]       rd2_addr_i,
	output logic [`MIPS_XLEN-1:0]            rd1_data_o,
	output logic [`MIPS_XLEN-1:0]            rd2_data_o
);

	// index 0 has no storage
	logic [`MIPS_XLEN-1:0] regs [1:`MIPS_NUM_REGS-1];

	// register 0 is hardwired and takes no writeback
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			regs <= '{default: '0};
		end else if (wr_i.en && wr_i.addr != '0) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// read with write-through of a same-cycle writeback
	function automatic logic [`MIPS_XLEN-1:0] read_port(input logic [`MIPS_REG_ADDR_W-1:0] addr);
		if (addr == '0) begin
			return '0;
		end
		if (wr_i.en && wr_i.addr == addr) begin
			return wr_i.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rd1_data_o = read_port(rd1_addr_i);
		rd2_data_o = read_port(rd2_addr_i);
	end

	// index 0 reads zero on both ports even under a writeback aimed at it
	zero_reg_reads_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(rd1_addr_i != '0 || rd1_data_o == '0) && (rd2_addr_i != '0 || rd2_data_o == '0));

endmodule

`default_nettype wire

// ==== hdl/id_decoder.sv ====
`default_nettype none

`include "mips_defines.svh"

module id_decoder (
	input  wire [`MIPS_XLEN-1:0]          inst_i,
	output mips_pipe_pkg::decode_ctrl_t  ctrl_o
);

	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	inst_fields_t          f;
	logic [15:0]           imm16;
	logic [`MIPS_XLEN-1:0] imm_zext;
	logic [`MIPS_XLEN-1:0] imm_sext;
	logic [`MIPS_XLEN-1:0] br_offset;    // sign-extended, word aligned
	logic [`MIPS_XLEN-1:0] jump_index;

	assign f          = inst_i;
	assign imm16      = inst_i[15:0];
	assign imm_zext   = {16'b0, imm16};
	assign imm_sext   = {{16{imm16[15]}}, imm16};
	assign br_offset  = {{14{imm16[15]}}, imm16, 2'b00};
	assign jump_index = {4'b0, inst_i[25:0], 2'b00};

	////////////////////////////////////////
	// operation lookup
	////////////////////////////////////////

	function automatic alu_op_e funct_op(input funct_e fn);
		case (fn)
			FN_AND:           return ALU_AND;
			FN_OR:            return ALU_OR;
			FN_XOR:           return ALU_XOR;
			FN_NOR:           return ALU_NOR;
			FN_SLL, FN_SLLV:  return ALU_SLL;    // shift amount source differs only
			FN_SRL, FN_SRLV:  return ALU_SRL;
			FN_SRA, FN_SRAV:  return ALU_SRA;
			FN_ADD:           return ALU_ADD;
			FN_ADDU:          return ALU_ADDU;
			FN_SUB:           return ALU_SUB;
			FN_SUBU:          return ALU_SUBU;
			FN_SLT:           return ALU_SLT;
			FN_SLTU:          return ALU_SLTU;
			FN_JR:            return ALU_JR;
			FN_JALR:          return ALU_JALR;
			default:          return ALU_NOP;
		endcase
	endfunction

	function automatic alu_op_e prim_op(input opcode_e op);
		case (op)
			OP_ANDI:         return ALU_AND;
			OP_ORI, OP_LUI:  return ALU_OR;    // lui is rs | upper immediate
			OP_XORI:         return ALU_XOR;
			OP_ADDI:         return ALU_ADDI;
			OP_ADDIU:        return ALU_ADDIU;
			OP_SLTI:         return ALU_SLT;
			OP_SLTIU:        return ALU_SLTU;
			OP_LW:           return ALU_LW;
			OP_SW:           return ALU_SW;
			OP_J:            return ALU_J;
			OP_JAL:          return ALU_JAL;
			OP_BEQ:          return ALU_BEQ;
			OP_BNE:          return ALU_BNE;
			OP_BLEZ:         return ALU_BLEZ;
			OP_BGTZ:         return ALU_BGTZ;
			default:         return ALU_NOP;
		endcase
	endfunction

	function automatic alu_sel_e sel_of(input alu_op_e op);
		case (op)
			ALU_AND, ALU_OR, ALU_XOR, ALU_NOR:             return SEL_LOGIC;
			ALU_SLL, ALU_SRL, ALU_SRA:                     return SEL_SHIFT;
			ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
			ALU_ADDI, ALU_ADDIU, ALU_SLT, ALU_SLTU:        return SEL_ARITH;
			ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
			ALU_BEQ, ALU_BNE, ALU_BLEZ, ALU_BGTZ:          return SEL_JUMP_BRANCH;
			ALU_LW, ALU_SW:                                return SEL_LOAD_STORE;
			default:                                       return SEL_NOP;
		endcase
	endfunction

	////////////////////////////////////////
	// operand shape per instruction
	////////////////////////////////////////

	always_comb begin
		ctrl_o          = '0;
		ctrl_o.rd1_addr = f.rs;
		ctrl_o.rd2_addr = f.rt;
		ctrl_o.br_kind  = BR_NONE;
		ctrl_o.alu_op   = (f.opcode == OP_SPECIAL) ? funct_op(f.funct) : prim_op(f.opcode);
		ctrl_o.alu_sel  = sel_of(ctrl_o.alu_op);

		case (f.opcode)
			OP_SPECIAL: begin
				if (ctrl_o.alu_op != ALU_NOP) begin    // unknown funct stays a nop
					ctrl_o.rd1_en = 1'b1;
					ctrl_o.rd2_en = 1'b1;
					ctrl_o.we     = 1'b1;
					ctrl_o.waddr  = f.rd;
				end
				case (f.funct)
					FN_SLL, FN_SRL, FN_SRA: begin
						ctrl_o.rd1_en = 1'b0;
						ctrl_o.imm    = `MIPS_XLEN'(f.shamt);
					end
					FN_JR, FN_JALR: begin
						ctrl_o.rd2_en  = 1'b0;
						ctrl_o.we      = (f.funct == FN_JALR);
						ctrl_o.br_kind = BR_JREG;
					end
					default: ;
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl_o.rd1_en = 1'b1;
				ctrl_o.we     = 1'b1;
				ctrl_o.waddr  = f.rt;
				ctrl_o.imm    = (f.opcode == OP_LUI) ? {imm16, 16'b0} : imm_zext;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LW: begin
				ctrl_o.rd1_en = 1'b1;
				ctrl_o.we     = 1'b1;
				ctrl_o.waddr  = f.rt;
				ctrl_o.imm    = imm_sext;
			end
			OP_SW: begin
				ctrl_o.rd1_en = 1'b1;    // base
				ctrl_o.rd2_en = 1'b1;    // store data
				ctrl_o.imm    = imm_sext;
			end
			OP_J, OP_JAL: begin
				ctrl_o.imm     = jump_index;
				ctrl_o.br_kind = BR_JUMP;
				if (f.opcode == OP_JAL) begin
					ctrl_o.we    = 1'b1;
					ctrl_o.waddr = `MIPS_REG_ADDR_W'(`MIPS_LINK_REG);
				end
			end
			OP_BEQ, OP_BNE: begin
				ctrl_o.rd1_en  = 1'b1;
				ctrl_o.rd2_en  = 1'b1;
				ctrl_o.imm     = br_offset;
				ctrl_o.br_kind = (f.opcode == OP_BEQ) ? BR_EQ : BR_NE;
			end
			OP_BLEZ, OP_BGTZ: begin
				ctrl_o.rd1_en  = 1'b1;
				ctrl_o.imm     = br_offset;
				ctrl_o.br_kind = (f.opcode == OP_BGTZ) ? BR_GTZ : BR_LEZ;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/id_operand_sel.sv ====
`default_nettype none

`include "mips_defines.svh"

module id_operand_sel (
	input  wire mips_pipe_pkg::decode_ctrl_t  ctrl_i,
	input  wire mips_pipe_pkg::fwd_bus_t      ex_fwd_i,
	input  wire mips_pipe_pkg::fwd_bus_t      mem_fwd_i,
	output logic [`MIPS_REG_ADDR_W-1:0]       rd1_addr_o,
	output logic [`MIPS_REG_ADDR_W-1:0]       rd2_addr_o,
	input  wire [`MIPS_XLEN-1:0]              rd1_data_i,
	input  wire [`MIPS_XLEN-1:0]              rd2_data_i,
	output logic [`MIPS_XLEN-1:0]             op1_o,
	output logic [`MIPS_XLEN-1:0]             op2_o,
	output logic                              stall_o
);

	import mips_pipe_pkg::*;

	// a port that does not read presents address 0 to the register file
	assign rd1_addr_o = ctrl_i.rd1_en ? ctrl_i.rd1_addr : '0;
	assign rd2_addr_o = ctrl_i.rd2_en ? ctrl_i.rd2_addr : '0;

	function automatic logic hits(input fwd_bus_t src, input logic [`MIPS_REG_ADDR_W-1:0] addr);
		return src.we && src.waddr == addr && addr != '0;
	endfunction

	// data of a lw still in execute is not there yet
	function automatic logic load_use(input logic en, input logic [`MIPS_REG_ADDR_W-1:0] addr,
			input fwd_bus_t ex);
		return en && ex.alu_op == ALU_LW && hits(ex, addr);
	endfunction

	// execute over memory over register file
	function automatic logic [`MIPS_XLEN-1:0] pick(input logic en,
			input logic [`MIPS_REG_ADDR_W-1:0] addr, input logic [`MIPS_XLEN-1:0] rf_data,
			input logic [`MIPS_XLEN-1:0] imm, input fwd_bus_t ex, input fwd_bus_t mem);
		if (!en) begin
			return imm;
		end
		if (hits(ex, addr)) begin
			return ex.wdata;
		end
		if (hits(mem, addr)) begin
			return mem.wdata;
		end
		return rf_data;
	endfunction

	assign op1_o = pick(ctrl_i.rd1_en, ctrl_i.rd1_addr, rd1_data_i, ctrl_i.imm, ex_fwd_i, mem_fwd_i);
	assign op2_o = pick(ctrl_i.rd2_en, ctrl_i.rd2_addr, rd2_data_i, ctrl_i.imm, ex_fwd_i, mem_fwd_i);

	assign stall_o = load_use(ctrl_i.rd1_en, ctrl_i.rd1_addr, ex_fwd_i)
		| load_use(ctrl_i.rd2_en, ctrl_i.rd2_addr, ex_fwd_i);

	// a stalling port presents the load's destination to the register file
	stall_needs_read: assert final (!stall_o || (ex_fwd_i.waddr != '0
		&& (rd1_addr_o == ex_fwd_i.waddr || rd2_addr_o == ex_fwd_i.waddr)));

endmodule

`default_nettype wire

// ==== hdl/id_branch_unit.sv ====
`default_nettype none

`include "mips_defines.svh"

module id_branch_unit (
	input  wire [`MIPS_XLEN-1:0]              pc_i,
	input  wire mips_pipe_pkg::decode_ctrl_t  ctrl_i,
	input  wire [`MIPS_XLEN-1:0]              op1_i,
	input  wire [`MIPS_XLEN-1:0]              op2_i,
	input  wire                               stall_i,
	output logic                              branch_flag_o,
	output logic [`MIPS_XLEN-1:0]             target_o,
	output logic [`MIPS_XLEN-1:0]             link_o,
	output logic                              next_in_delay_slot_o
);

	import mips_pipe_pkg::*;

	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic [`MIPS_XLEN-1:0] pc_plus8;    // return address skips the delay slot
	logic [`MIPS_XLEN-1:0] rel_target;
	logic                  taken;

	assign pc_plus4   = pc_i + 4;
	assign pc_plus8   = pc_i + 8;
	assign rel_target = pc_plus4 + ctrl_i.imm;

	always_comb begin
		taken    = 1'b0;
		target_o = '0;
		case (ctrl_i.br_kind)
			BR_JUMP: begin
				taken    = 1'b1;
				target_o = {pc_plus4[31:28], ctrl_i.imm[27:0]};    // 256 MB region
			end
			BR_JREG: begin
				taken    = 1'b1;
				target_o = op1_i;
			end
			BR_EQ, BR_NE: begin
				taken    = (op1_i == op2_i) ^ (ctrl_i.br_kind == BR_NE);
				target_o = rel_target;
			end
			BR_GTZ: begin
				taken    = $signed(op1_i) > 0;
				target_o = rel_target;
			end
			BR_LEZ: begin
				taken    = $signed(op1_i) <= 0;
				target_o = rel_target;
			end
			default: ;
		endcase
	end

	// operands are not final while stalled
	assign branch_flag_o        = taken && !stall_i;
	assign next_in_delay_slot_o = branch_flag_o;

	assign link_o = (ctrl_i.alu_op inside {ALU_JAL, ALU_JALR}) ? pc_plus8 : '0;

endmodule

`default_nettype wire

// ==== hdl/id_ex_reg.sv ====
`default_nettype none

`include "mips_defines.svh"

module id_ex_reg (
	input  wire                               clk_i,
	input  wire                               arst_n_i,
	input  wire mips_pipe_pkg::decode_ctrl_t  ctrl_i,
	input  wire [`MIPS_XLEN-1:0]              op1_i,
	input  wire [`MIPS_XLEN-1:0]              op2_i,
	input  wire [`MIPS_XLEN-1:0]              link_i,
	input  wire [`MIPS_XLEN-1:0]              inst_i,
	input  wire                               in_delay_slot_i,
	input  wire                               stall_i,
	output mips_pipe_pkg::id_ex_t             id_ex_o
);

	import mips_pipe_pkg::*;

	localparam id_ex_t id_ex_bubble = '{valid: 1'b0, alu_op: ALU_NOP, alu_sel: SEL_NOP,
		default: '0};

	id_ex_t id_ex_d;

	always_comb begin
		id_ex_d.valid         = 1'b1;
		id_ex_d.alu_op        = ctrl_i.alu_op;
		id_ex_d.alu_sel       = ctrl_i.alu_sel;
		id_ex_d.op1           = op1_i;
		id_ex_d.op2           = op2_i;
		id_ex_d.waddr         = ctrl_i.waddr;
		id_ex_d.we            = ctrl_i.we;
		id_ex_d.link_addr     = link_i;
		id_ex_d.in_delay_slot = in_delay_slot_i;
		id_ex_d.inst          = inst_i;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_o <= id_ex_bubble;
		end else if (stall_i) begin
			id_ex_o <= id_ex_bubble;    // decode holds, execute sees a nop
		end else begin
			id_ex_o <= id_ex_d;
		end
	end

	stall_gives_bubble: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		stall_i |=> !id_ex_o.valid);

endmodule

`default_nettype wire

// ==== hdl/id_stage_top.sv ====
`default_nettype none

`include "mips_defines.svh"

module id_stage_top (
	input  wire                           clk_i,
	input  wire                           arst_n_i,
	input  wire [`MIPS_XLEN-1:0]          pc_i,
	input  wire [`MIPS_XLEN-1:0]          inst_i,
	input  wire                           in_delay_slot_i,
	input  wire mips_pipe_pkg::fwd_bus_t  ex_fwd_i,
	input  wire mips_pipe_pkg::fwd_bus_t  mem_fwd_i,
	input  wire mips_pipe_pkg::gpr_wr_t   wb_i,
	output mips_pipe_pkg::id_ex_t         id_ex_o,
	output logic                          branch_flag_o,
	output logic [`MIPS_XLEN-1:0]         branch_target_o,
	output logic                          next_in_delay_slot_o,
	output logic                          stall_o
);

	import mips_pipe_pkg::*;

	decode_ctrl_t                ctrl;
	logic [`MIPS_REG_ADDR_W-1:0] rd1_addr;
	logic [`MIPS_REG_ADDR_W-1:0] rd2_addr;
	logic [`MIPS_XLEN-1:0]       rd1_data;
	logic [`MIPS_XLEN-1:0]       rd2_data;
	logic [`MIPS_XLEN-1:0]       op1;
	logic [`MIPS_XLEN-1:0]       op2;
	logic [`MIPS_XLEN-1:0]       link;

	////////////////////////////////////////
	// register file beside the decode logic
	////////////////////////////////////////

	gpr_file gpr_file_i (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.wr_i       (wb_i),
		.rd1_addr_i (rd1_addr),
		.rd2_addr_i (rd2_addr),
		.rd1_data_o (rd1_data),
		.rd2_data_o (rd2_data)
	);

	id_decoder id_decoder_i (
		.inst_i (inst_i),
		.ctrl_o (ctrl)
	);

	// forwarding and load-use detection
	id_operand_sel id_operand_sel_i (
		.ctrl_i     (ctrl),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.rd1_addr_o (rd1_addr),
		.rd2_addr_o (rd2_addr),
		.rd1_data_i (rd1_data),
		.rd2_data_i (rd2_data),
		.op1_o      (op1),
		.op2_o      (op2),
		.stall_o    (stall_o)
	);

	id_branch_unit id_branch_unit_i (
		.pc_i                 (pc_i),
		.ctrl_i               (ctrl),
		.op1_i                (op1),
		.op2_i                (op2),
		.stall_i              (stall_o),
		.branch_flag_o        (branch_flag_o),
		.target_o             (branch_target_o),
		.link_o               (link),
		.next_in_delay_slot_o (next_in_delay_slot_o)
	);

	id_ex_reg id_ex_reg_i (
		.clk_i           (clk_i),
		.arst_n_i        (arst_n_i),
		.ctrl_i          (ctrl),
		.op1_i           (op1),
		.op2_i           (op2),
		.link_i          (link),
		.inst_i          (inst_i),
		.in_delay_slot_i (in_delay_slot_i),
		.stall_i         (stall_o),
		.id_ex_o         (id_ex_o)
	);

endmodule

`default_nettype wire

// ==== dv/id_ref_model.svh ====
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// reference model of the decode stage, lives in the testbench module body

logic [`MIPS_XLEN-1:0] model_regs [`MIPS_NUM_REGS];

task automatic model_reset();
	foreach (model_regs[k]) begin
		model_regs[k] = '0;
	end
endtask

// takes effect at the edge that ends the cycle
task automatic model_write(input gpr_wr_t wb);
	if (wb.en && wb.addr != '0) begin
		model_regs[wb.addr] = wb.data;
	end
endtask

function automatic logic load_in_ex(input logic [4:0] addr, input fwd_bus_t ex);
	return ex.alu_op == ALU_LW && ex.we && ex.waddr == addr && addr != '0;
endfunction

// execute, then memory, then writeback in flight, then the register state
function automatic logic [31:0] operand_value(input logic [4:0] addr, input fwd_bus_t ex,
		input fwd_bus_t mem, input gpr_wr_t wb);
	if (addr == '0) return '0;
	if (ex.we && ex.waddr == addr) return ex.wdata;
	if (mem.we && mem.waddr == addr) return mem.wdata;
	if (wb.en && wb.addr == addr) return wb.data;
	return model_regs[addr];
endfunction

function automatic alu_sel_e class_of(input alu_op_e op);
	case (op)
		ALU_NOP:                           return SEL_NOP;
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: return SEL_LOGIC;
		ALU_SLL, ALU_SRL, ALU_SRA:         return SEL_SHIFT;
		ALU_LW, ALU_SW:                    return SEL_LOAD_STORE;
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
		ALU_BEQ, ALU_BNE, ALU_BLEZ, ALU_BGTZ: return SEL_JUMP_BRANCH;
		default:                           return SEL_ARITH;
	endcase
endfunction

task automatic predict(input logic [31:0] inst, input logic [31:0] pc, input logic dslot,
		input fwd_bus_t ex, input fwd_bus_t mem, input gpr_wr_t wb,
		output logic stall, output logic flag, output logic [31:0] target, output id_ex_t nxt);
	logic [5:0]  opc;
	logic [5:0]  fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  wa;
	logic [31:0] imm;
	logic [31:0] pc4;
	logic [31:0] op1;
	logic [31:0] op2;
	logic        rd1;
	logic        rd2;
	logic        we;
	logic        taken;
	alu_op_e     op;

	opc = inst[31:26];
	fn  = inst[5:0];
	rs  = inst[25:21];
	rt  = inst[20:16];
	imm = '0;
	if (opc == OP_SPECIAL) begin
		case (fn)
			FN_SLL, FN_SLLV: op = ALU_SLL;
			FN_SRLV:         op = ALU_SRL;
			FN_SRAV:         op = ALU_SRA;
			default:         op = alu_op_e'({2'b00, fn});    // register forms reuse funct
		endcase
		rd1 = !(fn inside {FN_SLL, FN_SRL, FN_SRA});    // fixed shifts take shamt instead
		rd2 = !(fn inside {FN_JR, FN_JALR});
		we  = (fn != FN_JR);
		wa  = inst[15:11];
		if (!rd1) imm = {27'b0, inst[10:6]};
	end else begin
		case (opc)
			OP_ANDI:        op = ALU_AND;
			OP_ORI, OP_LUI: op = ALU_OR;
			OP_XORI:        op = ALU_XOR;
			OP_ADDI:        op = ALU_ADDI;
			OP_ADDIU:       op = ALU_ADDIU;
			OP_SLTI:        op = ALU_SLT;
			OP_SLTIU:       op = ALU_SLTU;
			OP_LW:          op = ALU_LW;
			OP_SW:          op = ALU_SW;
			OP_J:           op = ALU_J;
			OP_JAL:         op = ALU_JAL;
			OP_BEQ:         op = ALU_BEQ;
			OP_BNE:         op = ALU_BNE;
			OP_BLEZ:        op = ALU_BLEZ;
			OP_BGTZ:        op = ALU_BGTZ;
			default:        op = ALU_NOP;
		endcase
		rd1 = !(opc inside {OP_J, OP_JAL});
		rd2 = opc inside {OP_SW, OP_BEQ, OP_BNE};
		we  = opc inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI,
			OP_SLTIU, OP_LW, OP_JAL};
		wa  = (opc == OP_JAL) ? 5'(`MIPS_LINK_REG) : (we ? rt : 5'd0);
		case (opc)
			OP_ANDI, OP_ORI, OP_XORI:         imm = {16'h0, inst[15:0]};
			OP_LUI:                           imm = {inst[15:0], 16'h0};
			OP_J, OP_JAL:                     imm = {4'h0, inst[25:0], 2'b00};
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: imm = {{14{inst[15]}}, inst[15:0], 2'b00};
			default:                          imm = {{16{inst[15]}}, inst[15:0]};
		endcase
	end

	op1   = rd1 ? operand_value(rs, ex, mem, wb) : imm;
	op2   = rd2 ? operand_value(rt, ex, mem, wb) : imm;
	stall = (rd1 && load_in_ex(rs, ex)) || (rd2 && load_in_ex(rt, ex));

	pc4 = pc + 32'd4;
	case (op)
		ALU_J, ALU_JAL:                       target = {pc4[31:28], inst[25:0], 2'b00};
		ALU_JR, ALU_JALR:                     target = op1;
		ALU_BEQ, ALU_BNE, ALU_BLEZ, ALU_BGTZ: target = pc4 + imm;
		default:                              target = '0;
	endcase
	case (op)
		ALU_J, ALU_JAL, ALU_JR, ALU_JALR: taken = 1'b1;
		ALU_BEQ:  taken = (op1 == op2);
		ALU_BNE:  taken = (op1 != op2);
		ALU_BGTZ: taken = $signed(op1) > 0;
		ALU_BLEZ: taken = $signed(op1) <= 0;
		default:  taken = 1'b0;
	endcase
	flag = taken && !stall;

	// a stalled cycle leaves a bubble behind
	nxt         = '0;
	nxt.alu_op  = ALU_NOP;
	nxt.alu_sel = SEL_NOP;
	if (!stall) begin
		nxt.valid         = 1'b1;
		nxt.alu_op        = op;
		nxt.alu_sel       = class_of(op);
		nxt.op1           = op1;
		nxt.op2           = op2;
		nxt.waddr         = wa;
		nxt.we            = we;
		nxt.link_addr     = (op inside {ALU_JAL, ALU_JALR}) ? pc + 32'd8 : '0;
		nxt.in_delay_slot = dslot;
		nxt.inst          = inst;
	end
endtask

`endif

// ==== dv/tb_id_stage.sv ====
`default_nettype none

`include "mips_defines.svh"

module tb_id_stage;

	timeunit 1ns;
	timeprecision 1ps;

	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_CYCLES   = 2000;

	localparam funct_e FN_SET [18] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
		FN_JR, FN_JALR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
		FN_SLT, FN_SLTU};
	localparam opcode_e OP_SET [16] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};

	logic                  clk_i;
	logic                  arst_n_i;
	logic [`MIPS_XLEN-1:0] pc_i;
	logic [`MIPS_XLEN-1:0] inst_i;
	logic                  in_delay_slot_i;
	fwd_bus_t              ex_fwd_i;
	fwd_bus_t              mem_fwd_i;
	gpr_wr_t               wb_i;
	id_ex_t                id_ex_o;
	logic                  branch_flag_o;
	logic [`MIPS_XLEN-1:0] branch_target_o;
	logic                  next_in_delay_slot_o;
	logic                  stall_o;

	logic [31:0] rng_state = 32'd44480;
	int          checks;
	int          errors;
	id_ex_t      exp_id_ex;    // what id_ex_o must show after the next edge

	`include "id_ref_model.svh"

	id_stage_top id_stage_top_i (.*);

	initial clk_i = 1'b0;
	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	////////////////////////////////////////
	// random stimulus
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// mostly low registers so indices collide often
	function automatic logic [4:0] rand_index();
		logic [31:0] r;
		r = xorshift32();
		return r[8] ? r[4:0] : {2'b00, r[2:0]};
	endfunction

	function automatic fwd_bus_t rand_fwd();
		fwd_bus_t    b;
		logic [31:0] r;
		r        = xorshift32();
		b.we     = r[0];
		b.waddr  = rand_index();
		b.wdata  = xorshift32();
		b.alu_op = (r[2:1] == 2'b00) ? ALU_LW : ALU_ADDU;    // a load one time in four
		return b;
	endfunction

	function automatic logic [31:0] rand_inst();
		logic [31:0] r;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shamt;
		funct_e      fn;
		opcode_e     op;
		r     = xorshift32();
		rs    = rand_index();
		rt    = rand_index();
		rd    = rand_index();
		fn    = FN_SET[r[8:4] % 18];
		op    = OP_SET[r[15:12]];
		shamt = (fn inside {FN_SLL, FN_SRL, FN_SRA}) ? r[20:16] : 5'd0;
		if (r[0]) return {OP_SPECIAL, rs, rt, rd, shamt, fn};
		if (op inside {OP_J, OP_JAL}) return {op, r[31:6]};
		return {op, rs, rt, r[31:16]};
	endfunction

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got %0h, expected %0h", name, got, exp);
		end
	endtask

	task automatic check_id_ex(input id_ex_t exp);
		check_value("id_ex_o.valid", id_ex_o.valid, exp.valid);
		check_value("id_ex_o.alu_op", id_ex_o.alu_op, exp.alu_op);
		check_value("id_ex_o.alu_sel", id_ex_o.alu_sel, exp.alu_sel);
		check_value("id_ex_o.op1", id_ex_o.op1, exp.op1);
		check_value("id_ex_o.op2", id_ex_o.op2, exp.op2);
		check_value("id_ex_o.waddr", id_ex_o.waddr, exp.waddr);
		check_value("id_ex_o.we", id_ex_o.we, exp.we);
		check_value("id_ex_o.link_addr", id_ex_o.link_addr, exp.link_addr);
		check_value("id_ex_o.in_delay_slot", id_ex_o.in_delay_slot, exp.in_delay_slot);
		check_value("id_ex_o.inst", id_ex_o.inst, exp.inst);
	endtask

	initial begin
		logic [31:0] r;
		logic        hold;
		logic        exp_stall;
		logic        exp_flag;
		logic [31:0] exp_target;
		id_ex_t      next_id_ex;
		gpr_wr_t     wb;

		arst_n_i        = 1'b0;
		pc_i            = '0;
		inst_i          = '0;
		in_delay_slot_i = 1'b0;
		ex_fwd_i        = '0;
		mem_fwd_i       = '0;
		wb_i            = '0;
		checks          = 0;
		errors          = 0;
		hold            = 1'b0;
		exp_id_ex       = '0;    // reset value is a bubble
		model_reset();

		repeat (RESET_CYCLES) @(posedge clk_i);
		arst_n_i <= 1'b1;
		for (int i = 0; i < NUM_CYCLES; i++) begin
			r = xorshift32();
			if (!hold) begin    // fetch holds the word while decode stalls
				inst_i <= rand_inst();
				pc_i   <= {r[31:2], 2'b00};
			end
			in_delay_slot_i <= r[3];
			ex_fwd_i        <= rand_fwd();
			mem_fwd_i       <= rand_fwd();
			// first pass fills every register in turn
			wb.en   = (i < `MIPS_NUM_REGS) ? 1'b1 : r[4];
			wb.addr = (i < `MIPS_NUM_REGS) ? 5'(i) : rand_index();
			wb.data = xorshift32();
			wb_i   <= wb;

			@(negedge clk_i);
			predict(inst_i, pc_i, in_delay_slot_i, ex_fwd_i, mem_fwd_i, wb_i,
				exp_stall, exp_flag, exp_target, next_id_ex);
			check_value("stall_o", stall_o, exp_stall);
			check_value("branch_flag_o", branch_flag_o, exp_flag);
			check_value("next_in_delay_slot_o", next_in_delay_slot_o, exp_flag);
			check_value("branch_target_o", branch_target_o, exp_target);
			check_id_ex(exp_id_ex);
			exp_id_ex = next_id_ex;
			model_write(wb_i);
			hold = exp_stall;
			@(posedge clk_i);
		end
		@(negedge clk_i);
		check_id_ex(exp_id_ex);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog
	initial begin
		#((RESET_CYCLES + NUM_CYCLES + 10) * CLK_PERIOD);
		$display("watchdog expired before the stimulus finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
+incdir+dv
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/gpr_file.sv
hdl/id_decoder.sv
hdl/id_operand_sel.sv
hdl/id_branch_unit.sv
hdl/id_ex_reg.sv
hdl/id_stage_top.sv
dv/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: mips_id_stage

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_isa_pkg.sv
      - hdl/mips_pipe_pkg.sv
      - hdl/gpr_file.sv
      - hdl/id_decoder.sv
      - hdl/id_operand_sel.sv
      - hdl/id_branch_unit.sv
      - hdl/id_ex_reg.sv
      - hdl/id_stage_top.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/tb_id_stage.sv
